/* rv_core_macros.svh */
`ifndef RV_CORE_MACROS_SVH
`define RV_CORE_MACROS_SVH

////////////////////////////////////////
// datapath widths
////////////////////////////////////////

// data and address width
`define RV_XLEN 32

// register file addressing
`define RV_REG_AW 5
`define RV_NREGS 32

////////////////////////////////////////
// fetch and flush values
////////////////////////////////////////

// first fetch address out of reset
`define RV_RESET_PC 32'h0000_0000

// addi x0, x0, 0
`define RV_NOP 32'h0000_0013

`endif

/* rv_core_pkg.sv */
`include "rv_core_macros.svh"

package rv_core_pkg;

    ////////////////////////////////////////
    // encodings
    ////////////////////////////////////////

    // supported major opcodes
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_LTU,
        BR_GEU
    } br_cond_e;

    typedef enum logic [1:0] {
        OP1_RS1,
        OP1_PC,
        OP1_ZERO
    } op1_sel_e;

    typedef enum logic [0:0] {
        OP2_RS2,
        OP2_IMM
    } op2_sel_e;

    ////////////////////////////////////////
    // stage records
    ////////////////////////////////////////

    typedef struct packed {
        alu_op_e               alu_op;
        br_cond_e              br_cond;
        logic                  is_jal;
        logic                  is_jalr;
        op1_sel_e              op1_sel;
        op2_sel_e              op2_sel;
        logic                  rf_wen;
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_REG_AW-1:0] rs1;
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_XLEN-1:0]   imm;
    } ctrl_t;

    // one forwarding source
    typedef struct packed {
        logic                  valid;
        logic [`RV_REG_AW-1:0] addr;
        logic [`RV_XLEN-1:0]   wdata;
    } fwd_t;

    typedef struct packed {
        logic                  valid;
        logic [`RV_XLEN-1:0]   pc;
        logic                  wen;
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_XLEN-1:0]   wdata;
    } retire_t;

    typedef struct packed {
        logic                  valid;
        logic [`RV_XLEN-1:0]   pc;
        logic                  is_br;
        logic                  is_jmp;
        logic                  taken;
        logic [`RV_XLEN-1:0]   target;
    } brinfo_t;

endpackage

/* rv_decoder.sv */
`include "rv_core_macros.svh"
`timescale 1ns/1ps

module rv_decoder import rv_core_pkg::*; (
    input  logic [`RV_XLEN-1:0] inst_i,
    output ctrl_t               ctrl_o
);

    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_j;
    logic [`RV_XLEN-1:0] imm_u;
    logic                legal;
    logic                shift_ok;
    logic                alt;

    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    // immediate formats
    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
    assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
    assign imm_u = {inst_i[31:12], 12'b0};

    // sub and sra share funct7 bit 5
    assign alt      = (funct7 == 7'b0100000);
    assign shift_ok = (funct7 == 7'b0000000) || (alt && funct3 == 3'b101);

    function automatic alu_op_e alu_of(input logic [2:0] f3, input logic sub_sra);
        case (f3)
            3'b000:  return sub_sra ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return sub_sra ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    always_comb begin
        ctrl_o         = '0;
        ctrl_o.alu_op  = ALU_ADD;
        ctrl_o.br_cond = BR_NONE;
        ctrl_o.op1_sel = OP1_ZERO;
        ctrl_o.op2_sel = OP2_IMM;
        ctrl_o.rd      = inst_i[11:7];
        ctrl_o.rs1     = inst_i[19:15];
        ctrl_o.rs2     = inst_i[24:20];
        legal          = 1'b0;
        case (opcode_e'(inst_i[6:0]))
            OP_LUI: begin
                legal         = 1'b1;
                ctrl_o.alu_op = ALU_PASS_B;
                ctrl_o.imm    = imm_u;
            end
            OP_AUIPC: begin
                legal          = 1'b1;
                ctrl_o.op1_sel = OP1_PC;
                ctrl_o.imm     = imm_u;
            end
            OP_JAL: begin
                legal          = 1'b1;
                ctrl_o.is_jal  = 1'b1;
                ctrl_o.op1_sel = OP1_PC;
                ctrl_o.imm     = imm_j;
            end
            OP_JALR: begin
                legal          = (funct3 == 3'b000);
                ctrl_o.is_jalr = legal;
                ctrl_o.op1_sel = OP1_RS1;
                ctrl_o.imm     = imm_i;
            end
            OP_BRANCH: begin
                case (funct3)
                    3'b000:  ctrl_o.br_cond = BR_EQ;
                    3'b001:  ctrl_o.br_cond = BR_NE;
                    3'b100:  ctrl_o.br_cond = BR_LT;
                    3'b101:  ctrl_o.br_cond = BR_GE;
                    3'b110:  ctrl_o.br_cond = BR_LTU;
                    3'b111:  ctrl_o.br_cond = BR_GEU;
                    default: ctrl_o.br_cond = BR_NONE;
                endcase
                ctrl_o.op1_sel = OP1_RS1;
                ctrl_o.op2_sel = OP2_RS2;
                ctrl_o.imm     = imm_b;
            end
            OP_IMM: begin
                // shifts constrain funct7, the rest take any imm
                legal          = (funct3[1:0] != 2'b01) || shift_ok;
                ctrl_o.alu_op  = alu_of(funct3, funct3 == 3'b101 && alt);
                ctrl_o.op1_sel = OP1_RS1;
                ctrl_o.imm     = imm_i;
            end
            OP_REG: begin
                legal          = (funct7 == 7'b0000000) || (alt && funct3 inside {3'b000, 3'b101});
                ctrl_o.alu_op  = alu_of(funct3, alt);
                ctrl_o.op1_sel = OP1_RS1;
                ctrl_o.op2_sel = OP2_RS2;
            end
            default: begin
                legal = 1'b0;
            end
        endcase
        // legal stays low for branches and unsupported encodings
        ctrl_o.rf_wen = legal && (ctrl_o.rd != '0);
    end

endmodule

/* rv_operand_select.sv */
`include "rv_core_macros.svh"
`timescale 1ns/1ps

module rv_operand_select import rv_core_pkg::*; (
    input  ctrl_t               ctrl_i,
    input  logic [`RV_XLEN-1:0] pc_i,
    input  logic [`RV_XLEN-1:0] rf_rdata1_i,
    input  logic [`RV_XLEN-1:0] rf_rdata2_i,
    input  fwd_t                fwd_exe_i,
    input  fwd_t                fwd_wb_i,
    output logic [`RV_XLEN-1:0] op1_o,
    output logic [`RV_XLEN-1:0] op2_o,
    output logic [`RV_XLEN-1:0] rs2_o
);

    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;

    // youngest producer first
    function automatic logic [`RV_XLEN-1:0] resolve(
        input logic [`RV_REG_AW-1:0] addr,
        input logic [`RV_XLEN-1:0]   rf_data,
        input fwd_t                  exe,
        input fwd_t                  wb
    );
        if (exe.valid && exe.addr == addr) begin
            return exe.wdata;
        end
        if (wb.valid && wb.addr == addr) begin
            return wb.wdata;
        end
        return rf_data;
    endfunction

    assign rs1_data = resolve(ctrl_i.rs1, rf_rdata1_i, fwd_exe_i, fwd_wb_i);
    assign rs2_data = resolve(ctrl_i.rs2, rf_rdata2_i, fwd_exe_i, fwd_wb_i);

    always_comb begin
        case (ctrl_i.op1_sel)
            OP1_RS1: op1_o = rs1_data;
            OP1_PC:  op1_o = pc_i;
            default: op1_o = '0;
        endcase
    end

    assign op2_o = (ctrl_i.op2_sel == OP2_IMM) ? ctrl_i.imm : rs2_data;
    assign rs2_o = rs2_data;

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    // x0 must never be forwarded, the decoder clears rf_wen for it
    always_comb begin
        if (fwd_exe_i.valid) begin
            assert (fwd_exe_i.addr != '0)
                else $error("execute forwarding names x0");
        end
        if (fwd_wb_i.valid) begin
            assert (fwd_wb_i.addr != '0)
                else $error("writeback forwarding names x0");
        end
    end

endmodule

/* rv_execute.sv */
`include "rv_core_macros.svh"
`timescale 1ns/1ps

module rv_execute import rv_core_pkg::*; (
    input  ctrl_t               ctrl_i,
    input  logic                valid_i,
    input  logic [`RV_XLEN-1:0] pc_i,
    input  logic [`RV_XLEN-1:0] op1_i,
    input  logic [`RV_XLEN-1:0] op2_i,
    input  logic [`RV_XLEN-1:0] rs2_i,
    output logic [`RV_XLEN-1:0] result_o,
    output logic                redirect_o,
    output logic [`RV_XLEN-1:0] target_o,
    output logic                taken_o,
    output fwd_t                fwd_exe_o
);

    logic [`RV_XLEN-1:0] alu_out;
    logic [4:0]          shamt;
    logic                cond_true;
    logic                is_jump;
    logic [`RV_XLEN-1:0] jalr_sum;

    assign shamt   = op2_i[4:0];
    assign is_jump = ctrl_i.is_jal || ctrl_i.is_jalr;

    always_comb begin
        case (ctrl_i.alu_op)
            ALU_ADD:    alu_out = op1_i + op2_i;
            ALU_SUB:    alu_out = op1_i - op2_i;
            ALU_SLL:    alu_out = op1_i << shamt;
            ALU_SLT:    alu_out = {{(`RV_XLEN-1){1'b0}}, $signed(op1_i) < $signed(op2_i)};
            ALU_SLTU:   alu_out = {{(`RV_XLEN-1){1'b0}}, op1_i < op2_i};
            ALU_XOR:    alu_out = op1_i ^ op2_i;
            ALU_SRL:    alu_out = op1_i >> shamt;
            ALU_SRA:    alu_out = $unsigned($signed(op1_i) >>> shamt);
            ALU_OR:     alu_out = op1_i | op2_i;
            ALU_AND:    alu_out = op1_i & op2_i;
            ALU_PASS_B: alu_out = op2_i;
            default:    alu_out = '0;
        endcase
    end

    // branch compare, op1 carries rs1 data for branches
    always_comb begin
        case (ctrl_i.br_cond)
            BR_EQ:   cond_true = (op1_i == rs2_i);
            BR_NE:   cond_true = (op1_i != rs2_i);
            BR_LT:   cond_true = $signed(op1_i) < $signed(rs2_i);
            BR_GE:   cond_true = $signed(op1_i) >= $signed(rs2_i);
            BR_LTU:  cond_true = op1_i < rs2_i;
            BR_GEU:  cond_true = op1_i >= rs2_i;
            default: cond_true = 1'b0;
        endcase
    end

    assign jalr_sum   = op1_i + ctrl_i.imm;
    assign target_o   = ctrl_i.is_jalr ? {jalr_sum[`RV_XLEN-1:1], 1'b0} : pc_i + ctrl_i.imm;
    assign taken_o    = cond_true || is_jump;
    assign redirect_o = valid_i && taken_o;

    // jumps write the link address
    assign result_o = is_jump ? pc_i + 32'd4 : alu_out;

    assign fwd_exe_o = '{valid: valid_i && ctrl_i.rf_wen, addr: ctrl_i.rd, wdata: result_o};

    always_comb begin
        if (redirect_o) begin
            assert (target_o[1:0] == 2'b00)
                else $error("redirect target %h is not word aligned", target_o);
        end
    end

endmodule

/* rv_writeback.sv */
`include "rv_core_macros.svh"
`timescale 1ns/1ps

module rv_writeback import rv_core_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  valid_i,
    input  logic [`RV_XLEN-1:0]   pc_i,
    input  ctrl_t                 ctrl_i,
    input  logic [`RV_XLEN-1:0]   result_i,
    input  logic [`RV_REG_AW-1:0] rs1_addr_i,
    input  logic [`RV_REG_AW-1:0] rs2_addr_i,
    output logic [`RV_XLEN-1:0]   rf_rdata1_o,
    output logic [`RV_XLEN-1:0]   rf_rdata2_o,
    output fwd_t                  fwd_wb_o,
    output retire_t               retire_o
);

    logic                  wb_valid;
    logic [`RV_XLEN-1:0]   wb_pc;
    logic                  wb_wen;
    logic [`RV_REG_AW-1:0] wb_rd;
    logic [`RV_XLEN-1:0]   wb_wdata;
    logic [`RV_XLEN-1:0]   rf [`RV_NREGS];

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        wb_pc    <= pc_i;
        wb_wen   <= ctrl_i.rf_wen;
        wb_rd    <= ctrl_i.rd;
        wb_wdata <= result_i;
    end

    // written at the end of the retire cycle, rd is never x0 here
    always_ff @(posedge clk) begin
        if (wb_valid && wb_wen) begin
            rf[wb_rd] <= wb_wdata;
        end
    end

    assign rf_rdata1_o = (rs1_addr_i == '0) ? '0 : rf[rs1_addr_i];
    assign rf_rdata2_o = (rs2_addr_i == '0) ? '0 : rf[rs2_addr_i];

    assign fwd_wb_o = '{valid: wb_valid && wb_wen, addr: wb_rd, wdata: wb_wdata};
    assign retire_o = '{valid: wb_valid, pc: wb_pc, wen: wb_wen, rd: wb_rd, wdata: wb_wdata};

endmodule

/* rv_core.sv */
`include "rv_core_macros.svh"
`timescale 1ns/1ps

module rv_core import rv_core_pkg::*; (
    input  logic                clk,
    input  logic                rst_n_i,
    output logic [`RV_XLEN-1:0] inst_addr_o,
    input  logic [`RV_XLEN-1:0] inst_i,
    output retire_t             retire_o,
    output brinfo_t             brinfo_o
);

    // fetch
    logic [`RV_XLEN-1:0] pc_q;

    // decode
    logic                id_valid;
    logic [`RV_XLEN-1:0] id_pc;
    logic [`RV_XLEN-1:0] id_inst;
    ctrl_t               id_ctrl;

    // operand select
    logic                ds_valid;
    logic [`RV_XLEN-1:0] ds_pc;
    ctrl_t               ds_ctrl;
    logic [`RV_XLEN-1:0] ds_op1;
    logic [`RV_XLEN-1:0] ds_op2;
    logic [`RV_XLEN-1:0] ds_rs2;
    logic [`RV_XLEN-1:0] rf_rdata1;
    logic [`RV_XLEN-1:0] rf_rdata2;

    // execute
    logic                ex_valid;
    logic [`RV_XLEN-1:0] ex_pc;
    ctrl_t               ex_ctrl;
    logic [`RV_XLEN-1:0] ex_op1;
    logic [`RV_XLEN-1:0] ex_op2;
    logic [`RV_XLEN-1:0] ex_rs2;
    logic [`RV_XLEN-1:0] ex_result;
    logic                ex_redirect;
    logic [`RV_XLEN-1:0] ex_target;
    logic                ex_taken;

    fwd_t                fwd_exe;
    fwd_t                fwd_wb;
    brinfo_t             brinfo_q;

    ////////////////////////////////////////
    // fetch and valid bits
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q     <= `RV_RESET_PC;
            id_valid <= 1'b0;
            ds_valid <= 1'b0;
            ex_valid <= 1'b0;
        end else begin
            pc_q     <= ex_redirect ? ex_target : pc_q + 32'd4;
            // a redirect kills everything younger than execute
            id_valid <= !ex_redirect;
            ds_valid <= id_valid && !ex_redirect;
            ex_valid <= ds_valid && !ex_redirect;
        end
    end

    assign inst_addr_o = pc_q;

    always_ff @(posedge clk) begin
        id_pc   <= pc_q;
        id_inst <= ex_redirect ? `RV_NOP : inst_i;
        ds_pc   <= id_pc;
        ds_ctrl <= id_ctrl;
        ex_pc   <= ds_pc;
        ex_ctrl <= ds_ctrl;
        ex_op1  <= ds_op1;
        ex_op2  <= ds_op2;
        ex_rs2  <= ds_rs2;
    end

    ////////////////////////////////////////
    // stages
    ////////////////////////////////////////

    rv_decoder u_decoder (
        .inst_i (id_inst),
        .ctrl_o (id_ctrl)
    );

    rv_operand_select u_operand_select (
        .ctrl_i      (ds_ctrl),
        .pc_i        (ds_pc),
        .rf_rdata1_i (rf_rdata1),
        .rf_rdata2_i (rf_rdata2),
        .fwd_exe_i   (fwd_exe),
        .fwd_wb_i    (fwd_wb),
        .op1_o       (ds_op1),
        .op2_o       (ds_op2),
        .rs2_o       (ds_rs2)
    );

    rv_execute u_execute (
        .ctrl_i     (ex_ctrl),
        .valid_i    (ex_valid),
        .pc_i       (ex_pc),
        .op1_i      (ex_op1),
        .op2_i      (ex_op2),
        .rs2_i      (ex_rs2),
        .result_o   (ex_result),
        .redirect_o (ex_redirect),
        .target_o   (ex_target),
        .taken_o    (ex_taken),
        .fwd_exe_o  (fwd_exe)
    );

    rv_writeback u_writeback (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .valid_i     (ex_valid),
        .pc_i        (ex_pc),
        .ctrl_i      (ex_ctrl),
        .result_i    (ex_result),
        .rs1_addr_i  (ds_ctrl.rs1),
        .rs2_addr_i  (ds_ctrl.rs2),
        .rf_rdata1_o (rf_rdata1),
        .rf_rdata2_o (rf_rdata2),
        .fwd_wb_o    (fwd_wb),
        .retire_o    (retire_o)
    );

    // branch record, one cycle after execute
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            brinfo_q <= '0;
        end else begin
            brinfo_q.valid  <= ex_valid &&
                               (ex_ctrl.br_cond != BR_NONE || ex_ctrl.is_jal || ex_ctrl.is_jalr);
            brinfo_q.pc     <= ex_pc;
            brinfo_q.is_br  <= ex_ctrl.br_cond != BR_NONE;
            brinfo_q.is_jmp <= ex_ctrl.is_jal || ex_ctrl.is_jalr;
            brinfo_q.taken  <= ex_taken;
            brinfo_q.target <= ex_target;
        end
    end

    assign brinfo_o = brinfo_q;

    // wrong-path instructions must be gone once the redirect lands
    assert property (@(posedge clk) disable iff (!rst_n_i)
        ex_redirect |=> !id_valid && !ds_valid && !ex_valid)
        else $error("younger stage still valid after redirect");

endmodule

/* tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 40
) (
    output logic clk_o
);

    // free running, starts low
    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk_o = ~clk_o;
        end
    end

endmodule

/* tb_rv_core.sv */
`include "rv_core_macros.svh"
`timescale 1ns/1ps

module tb_rv_core import rv_core_pkg::*; ();

    localparam int ROM_WORDS   = 64;
    localparam int INIT_WORDS  = 7;
    localparam int N_RETIRE    = 2000;
    localparam int CYCLE_LIMIT = 20000;

    logic                clk;
    logic                rst_n;
    logic [`RV_XLEN-1:0] inst_addr;
    logic [`RV_XLEN-1:0] inst;
    retire_t             retire;
    brinfo_t             brinfo;

    logic [`RV_XLEN-1:0] rom [ROM_WORDS];
    logic [`RV_XLEN-1:0] m_regs [`RV_NREGS];
    logic [`RV_XLEN-1:0] m_pc;
    brinfo_t             br_queue [$];
    int                  retired;

    tb_clock #(.PERIOD_NS(40)) u_clock (.clk_o(clk));

    rv_core rv_core_inst (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .inst_addr_o (inst_addr),
        .inst_i      (inst),
        .retire_o    (retire),
        .brinfo_o    (brinfo)
    );

    ////////////////////////////////////////
    // program ROM
    ////////////////////////////////////////

    function automatic logic [`RV_XLEN-1:0] rom_read(input logic [`RV_XLEN-1:0] addr);
        if (addr[`RV_XLEN-1:8] != '0) begin
            return `RV_NOP;
        end
        return rom[addr[7:2]];
    endfunction

    // x0..x7 only, so dependencies are frequent
    function automatic logic [4:0] rand_reg();
        return 5'($urandom % 8);
    endfunction

    // control flow only goes forward, the last word loops back past the init words
    function automatic logic [`RV_XLEN-1:0] make_inst(input int idx);
        logic [31:0] offs;
        logic [11:0] imm12;
        logic [2:0]  f3;
        logic [6:0]  f7;
        int          kind;
        int          tgt;
        kind  = (idx == ROM_WORDS - 1) ? 13 : int'($urandom % 16);
        tgt   = (idx == ROM_WORDS - 1) ? INIT_WORDS
                : idx + 1 + int'($urandom % (ROM_WORDS - 1 - idx));
        offs  = 32'((tgt - idx) * 4);
        f3    = 3'($urandom % 8);
        imm12 = 12'($urandom);
        case (kind)
            0: return {20'($urandom), rand_reg(), 7'b0110111};
            1: return {20'($urandom), rand_reg(), 7'b0010111};
            2, 3, 4, 5, 6: begin
                if (f3 == 3'b001 || f3 == 3'b101) begin
                    f7    = (f3 == 3'b101 && $urandom % 2 == 1) ? 7'b0100000 : 7'b0000000;
                    imm12 = {f7, imm12[4:0]};
                end
                return {imm12, rand_reg(), f3, rand_reg(), 7'b0010011};
            end
            7, 8, 9, 10: begin
                f7 = ((f3 == 3'b000 || f3 == 3'b101) && $urandom % 2 == 1) ? 7'b0100000 : 7'b0;
                return {f7, rand_reg(), rand_reg(), f3, rand_reg(), 7'b0110011};
            end
            11, 12: begin
                // funct3 010 and 011 are not branches
                f3 = (f3[2:1] == 2'b01) ? 3'b000 : f3;
                return {offs[12], offs[10:5], rand_reg(), rand_reg(), f3,
                        offs[4:1], offs[11], 7'b1100011};
            end
            13: return {offs[20], offs[10:1], offs[11], offs[19:12], rand_reg(), 7'b1101111};
            14: return {12'(tgt * 4), 5'd0, 3'b000, rand_reg(), 7'b1100111};
            // a load, which the core treats as a no-op
            default: return {imm12, rand_reg(), 3'b010, rand_reg(), 7'b0000011};
        endcase
    endfunction

    ////////////////////////////////////////
    // instruction-set model
    ////////////////////////////////////////

    function automatic logic [31:0] alu(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic model_step(output retire_t exp);
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_b;
        logic [31:0] imm_j;
        logic [31:0] res;
        logic        writes;
        brinfo_t     br;
        ins    = rom_read(m_pc);
        a      = m_regs[ins[19:15]];
        b      = m_regs[ins[24:20]];
        imm_i  = {{20{ins[31]}}, ins[31:20]};
        imm_b  = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_j  = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        res    = m_pc + 32'd4;
        writes = 1'b1;
        br     = '0;
        case (ins[6:0])
            7'b0110111: res = {ins[31:12], 12'b0};
            7'b0010111: res = m_pc + {ins[31:12], 12'b0};
            7'b0010011: res = alu(ins[14:12], ins[30] && ins[14:12] == 3'b101, a, imm_i);
            7'b0110011: res = alu(ins[14:12], ins[30], a, b);
            7'b1101111: br = '{valid: 1'b1, pc: m_pc, is_br: 1'b0, is_jmp: 1'b1,
                               taken: 1'b1, target: m_pc + imm_j};
            7'b1100111: br = '{valid: 1'b1, pc: m_pc, is_br: 1'b0, is_jmp: 1'b1,
                               taken: 1'b1, target: (a + imm_i) & ~32'd1};
            7'b1100011: begin
                writes = 1'b0;
                br     = '{valid: 1'b1, pc: m_pc, is_br: 1'b1, is_jmp: 1'b0,
                           taken: branch_taken(ins[14:12], a, b), target: m_pc + imm_b};
            end
            default: writes = 1'b0;
        endcase
        exp = '{valid: 1'b1, pc: m_pc, wen: writes && ins[11:7] != '0, rd: ins[11:7],
                wdata: res};
        if (exp.wen) begin
            m_regs[exp.rd] = res;
        end
        if (br.valid) begin
            br_queue.push_back(br);
        end
        m_pc = (br.valid && br.taken) ? br.target : m_pc + 32'd4;
    endtask

    ////////////////////////////////////////
    // checks
    ////////////////////////////////////////

    task automatic abort_run();
        $display("sim failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_retire(input retire_t got, input retire_t exp);
        if (got.valid !== exp.valid || (exp.valid && (got.pc !== exp.pc ||
            got.wen !== exp.wen || got.rd !== exp.rd ||
            (exp.wen && got.wdata !== exp.wdata)))) begin
            $display("Mismatch at %0t: retire v%b pc %h wen %b rd %0d wdata %h", $time,
                     got.valid, got.pc, got.wen, got.rd, got.wdata);
            $display("  expected v%b pc %h wen %b rd %0d wdata %h",
                     exp.valid, exp.pc, exp.wen, exp.rd, exp.wdata);
            abort_run();
        end
    endtask

    task automatic check_brinfo(input brinfo_t got, input brinfo_t exp);
        if (got.valid !== exp.valid || (exp.valid && got !== exp)) begin
            $display("Mismatch at %0t: branch v%b pc %h br %b jmp %b taken %b target %h",
                     $time, got.valid, got.pc, got.is_br, got.is_jmp, got.taken, got.target);
            $display("  expected v%b pc %h br %b jmp %b taken %b target %h",
                     exp.valid, exp.pc, exp.is_br, exp.is_jmp, exp.taken, exp.target);
            abort_run();
        end
    endtask

    task automatic check_addr(input logic [`RV_XLEN-1:0] got, input logic [`RV_XLEN-1:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: fetch address %h, expected %h", $time, got, exp);
            abort_run();
        end
    endtask

    // a branch retires in the same cycle as its record
    task automatic sample_outputs();
        retire_t exp_ret;
        if (retire.valid) begin
            model_step(exp_ret);
            check_retire(retire, exp_ret);
            retired++;
        end
        if (brinfo.valid && br_queue.size() == 0) begin
            $display("unexpected branch record at %0t for pc %h", $time, brinfo.pc);
            abort_run();
        end else if (brinfo.valid) begin
            check_brinfo(brinfo, br_queue.pop_front());
        end else if (br_queue.size() != 0) begin
            $display("branch at pc %h retired without a branch record", br_queue[0].pc);
            abort_run();
        end
    endtask

    initial begin
        int cycles;
        rst_n   = 1'b0;
        inst    = `RV_NOP;
        retired = 0;
        cycles  = 0;
        void'($urandom(32'h2e9e_5d01));
        // seed x1..x7 first
        for (int i = 0; i < INIT_WORDS; i++) begin
            rom[i] = {12'($urandom), 5'd0, 3'b000, 5'(i + 1), 7'b0010011};
        end
        for (int i = INIT_WORDS; i < ROM_WORDS; i++) begin
            rom[i] = make_inst(i);
        end
        for (int i = 0; i < `RV_NREGS; i++) begin
            m_regs[i] = '0;
        end
        m_pc = `RV_RESET_PC;
        repeat (2) begin
            @(negedge clk);
            check_retire(retire, '0);
            check_brinfo(brinfo, '0);
            check_addr(inst_addr, `RV_RESET_PC);
        end
        rst_n = 1'b1;
        inst  = rom_read(inst_addr);
        while (retired < N_RETIRE && cycles < CYCLE_LIMIT) begin
            @(negedge clk);
            cycles++;
            sample_outputs();
            inst = rom_read(inst_addr);
        end
        if (retired < N_RETIRE) begin
            $display("timeout: %0d of %0d instructions retired in %0d cycles",
                     retired, N_RETIRE, cycles);
            abort_run();
        end else begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

/* list.f */
+incdir+.
rv_core_pkg.sv
rv_decoder.sv
rv_operand_select.sv
rv_execute.sv
rv_writeback.sv
rv_core.sv
tb_clock.sv
tb_rv_core.sv

/* Makefile */
TOP := tb_rv_core
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f list.f \
		-Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) 2>&1 | tee $(LOG)
	grep -q "sim passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
